// File: files.f
logic/hostMapPkg.sv
logic/coreCfgPkg.sv
logic/bankWriteIf.sv
logic/hostDecoder.sv
logic/inputBank.sv
logic/configRegBank.sv
logic/statusReadback.sv
logic/aipTop.sv
testbench/aipTop_checker.sv
testbench/aipTb.sv

// File: logic/aipTop.sv
`timescale 1ns/1ps

module aipTop
  import hostMapPkg::*, coreCfgPkg::*;
#(
  parameter int unsigned Banks                  = NumBanks,
  parameter int unsigned AddrWidths [NumBanks]  = BankAddrWidths,
  parameter int unsigned ConfWords              = NumConfWords,
  parameter logic [31:0] IdValue                = CoreId
) (
  input  logic                     clk,
  input  logic                     rst,

  // Host side
  input  cmdCodeT                  cmdCode_i,
  input  dataWordT                 hostData_i,
  input  logic                     hostWrite_i,
  input  logic                     hostStart_i,
  output dataWordT                 hostData_o,
  output logic                     hostInt_o,

  // Core side
  input  logic [MaxAddrWidth-1:0]  coreRdAddr_i [Banks],
  output dataWordT                 coreRdData_o [Banks],
  output dataWordT [ConfWords-1:0] confData_o,
  output logic                     coreStart_o,
  input  logic                     coreBusy_i,
  input  logic                     coreDone_i
);

  logic confWrite;
  logic confPtrLoad;
  logic statusWrite;

  bankWriteIf bankWr [Banks] ();

  hostDecoder #(
    .Banks (Banks)
  ) uDecoder (
    .cmdCode_i     (cmdCode_i),
    .hostData_i    (hostData_i),
    .hostWrite_i   (hostWrite_i),
    .banks_o       (bankWr),
    .confWrite_o   (confWrite),
    .confPtrLoad_o (confPtrLoad),
    .statusWrite_o (statusWrite)
  );

  // Input memories, drained by the core
  for (genvar b = 0; b < Banks; b++) begin : gBank
    inputBank #(
      .AddrWidth (AddrWidths[b])
    ) uBank (
      .clk      (clk),
      .rst      (rst),
      .wr_i     (bankWr[b]),
      .rdAddr_i (coreRdAddr_i[b]),
      .rdData_o (coreRdData_o[b])
    );
  end

  configRegBank #(
    .NumWords (ConfWords)
  ) uConfig (
    .clk        (clk),
    .rst        (rst),
    .write_i    (confWrite),
    .ptrLoad_i  (confPtrLoad),
    .hostData_i (hostData_i),
    .confData_o (confData_o)
  );

  statusReadback #(
    .IdWord (IdValue)
  ) uStatus (
    .clk           (clk),
    .rst           (rst),
    .statusWrite_i (statusWrite),
    .cmdCode_i     (cmdCode_i),
    .hostData_i    (hostData_i),
    .coreBusy_i    (coreBusy_i),
    .coreDone_i    (coreDone_i),
    .hostData_o    (hostData_o),
    .hostInt_o     (hostInt_o)
  );

  assign coreStart_o = hostStart_i; // Straight through to the core

endmodule

// File: logic/bankWriteIf.sv
`timescale 1ns/1ps

interface bankWriteIf
  import hostMapPkg::*, coreCfgPkg::*;
();

  logic                    wrEn;     // Data write, pointer advances
  logic                    ptrLoad;  // Pointer load from loadAddr
  dataWordT                wrData;
  logic [MaxAddrWidth-1:0] loadAddr;

  modport source (
    output wrEn,
    output ptrLoad,
    output wrData,
    output loadAddr
  );

  modport sink (
    input wrEn,
    input ptrLoad,
    input wrData,
    input loadAddr
  );

endinterface

// File: logic/configRegBank.sv
`timescale 1ns/1ps

module configRegBank
  import hostMapPkg::*;
#(
  parameter int unsigned NumWords = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      write_i,
  input  logic                      ptrLoad_i,
  input  dataWordT                  hostData_i,
  output dataWordT [NumWords-1:0]   confData_o
);

  localparam int unsigned PtrWidth = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam logic [PtrWidth-1:0] LastWord = PtrWidth'(NumWords - 1);

  logic [PtrWidth-1:0] wrPtr;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr      <= '0;
      confData_o <= '0;
    end else if (ptrLoad_i) begin
      wrPtr <= hostData_i[PtrWidth-1:0];
    end else if (write_i) begin
      confData_o[wrPtr] <= hostData_i;
      // Wrap after the last word
      if (wrPtr >= LastWord) begin
        wrPtr <= '0;
      end else begin
        wrPtr <= wrPtr + 1'b1;
      end
    end
  end

endmodule

// File: logic/coreCfgPkg.sv
package coreCfgPkg;

  localparam int unsigned NumBanks = 3;

  // Index 0 is bank 0
  localparam int unsigned BankAddrWidths [NumBanks] = '{5, 5, 6};

  // Width of the core read address ports
  localparam int unsigned MaxAddrWidth = 16;

  localparam int unsigned NumConfWords = 2;

  localparam logic [31:0] CoreId = 32'h1000500A;

  // Status word layout
  localparam int unsigned StatBusyBit  = 0;  // Live busy from the core
  localparam int unsigned StatDoneBit  = 8;  // Done pending, write one to clear
  localparam int unsigned StatIntEnBit = 16; // Interrupt enable

endpackage

// File: logic/hostDecoder.sv
`timescale 1ns/1ps

module hostDecoder
  import hostMapPkg::*, coreCfgPkg::*;
#(
  parameter int unsigned Banks = NumBanks
) (
  input  cmdCodeT           cmdCode_i,
  input  dataWordT          hostData_i,
  input  logic              hostWrite_i,
  bankWriteIf.source        banks_o [Banks],
  output logic              confWrite_o,
  output logic              confPtrLoad_o,
  output logic              statusWrite_o
);

  localparam int unsigned CmdSpace = 2 ** $bits(cmdCodeT);

  // One strobe per command code, only while the host writes
  logic [CmdSpace-1:0] cmdHit;

  assign cmdHit = {{(CmdSpace - 1){1'b0}}, hostWrite_i} << cmdCode_i;

  for (genvar b = 0; b < Banks; b++) begin : gBankStrobe
    assign banks_o[b].wrEn     = cmdHit[CmdBankDataBase + 2 * b];
    assign banks_o[b].ptrLoad  = cmdHit[CmdBankDataBase + 2 * b + 1];
    assign banks_o[b].wrData   = hostData_i;
    assign banks_o[b].loadAddr = hostData_i[MaxAddrWidth-1:0]; // Bank keeps its low bits
  end

  assign confWrite_o   = cmdHit[CmdConfData];
  assign confPtrLoad_o = cmdHit[CmdConfPtr];

  // Readback of code 31 needs no strobe, only status is writable
  assign statusWrite_o = cmdHit[CmdStatus];

endmodule

// File: logic/hostMapPkg.sv
package hostMapPkg;

  // Host and memory data word
  typedef logic [31:0] dataWordT;

  // Command code driven by the host
  typedef logic [4:0] cmdCodeT;

  // Bank i takes data at 2i and a pointer load at 2i+1
  localparam cmdCodeT CmdBankDataBase = 5'd0;

  localparam cmdCodeT CmdConfData = 5'd6; // Config word write
  localparam cmdCodeT CmdConfPtr  = 5'd7; // Config pointer load

  // Readback and status codes
  localparam cmdCodeT CmdStatus = 5'd30;
  localparam cmdCodeT CmdId     = 5'd31;

  // Value seen on the host data output for codes without readback
  localparam dataWordT ReadIdle = '0;

endpackage

// File: logic/inputBank.sv
`timescale 1ns/1ps

module inputBank
  import hostMapPkg::*, coreCfgPkg::*;
#(
  parameter int unsigned AddrWidth = 5
) (
  input  logic                    clk,
  input  logic                    rst,
  bankWriteIf.sink                wr_i,
  input  logic [MaxAddrWidth-1:0] rdAddr_i,
  output dataWordT                rdData_o
);

  localparam int unsigned Depth = 2 ** AddrWidth;

  dataWordT             mem [Depth];
  logic [AddrWidth-1:0] wrPtr;

  // Write pointer, a load wins over a data write
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr <= '0;
    end else if (wr_i.ptrLoad) begin
      wrPtr <= wr_i.loadAddr[AddrWidth-1:0];
    end else if (wr_i.wrEn) begin
      wrPtr <= wrPtr + 1'b1; // Wraps at bank depth
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i.wrEn) begin
      mem[wrPtr] <= wr_i.wrData;
    end
  end

  // Core side, one cycle of latency
  always_ff @(posedge clk) begin
    rdData_o <= mem[rdAddr_i[AddrWidth-1:0]];
  end

endmodule

// File: logic/statusReadback.sv
`timescale 1ns/1ps

module statusReadback
  import hostMapPkg::*, coreCfgPkg::*;
#(
  parameter logic [31:0] IdWord = CoreId
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     statusWrite_i,
  input  cmdCodeT  cmdCode_i,
  input  dataWordT hostData_i,
  input  logic     coreBusy_i,
  input  logic     coreDone_i,
  output dataWordT hostData_o,
  output logic     hostInt_o
);

  logic     donePend;
  logic     intEn;
  dataWordT statusWord;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      donePend  <= 1'b0;
      intEn     <= 1'b0;
      hostInt_o <= 1'b0;
    end else begin
      if (coreDone_i) begin
        donePend <= 1'b1; // Beats a clear in the same cycle
      end else if (statusWrite_i && hostData_i[StatDoneBit]) begin
        donePend <= 1'b0;
      end
      if (statusWrite_i) begin
        intEn <= hostData_i[StatIntEnBit];
      end
      hostInt_o <= donePend & intEn;
    end
  end

  always_comb begin
    statusWord               = '0;
    statusWord[StatBusyBit]  = coreBusy_i;
    statusWord[StatDoneBit]  = donePend;
    statusWord[StatIntEnBit] = intEn;
  end

  // Same cycle readback
  always_comb begin
    case (cmdCode_i)
      CmdStatus: hostData_o = statusWord;
      CmdId:     hostData_o = IdWord;
      default:   hostData_o = ReadIdle;
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module aipTb -f files.f -o aipSim \
  && ./obj_dir/aipSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run stopped with an error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log \
  && { echo "Simulation reported a failure"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// File: testbench/aipCases.txt
# Hex fields: T name | W code data | R code expect | F bank count | M bank addr count
# C bank addr expect | K word expect | B busy | D | S start | I int | N cycles
T readback
R 1f 1000500a
B 1
R 1e 00000001
B 0
R 1e 00000000
R c 00000000
# Bank 0 burst wraps from 31 to 0
T bank0_wrap
W 1 1c
F 0 8
M 0 1c 8
W 0 cafef00d
C 0 4 cafef00d
# Bank 1 pointer starts at 0 after reset
T bank1_reset_ptr
F 1 6
M 1 0 6
# Bank 2 above address 31 and across its own wrap
T bank2_high
W 5 20
F 2 18
M 2 20 18
W 5 3e
W 4 0badc0de
F 2 2
C 2 3e 0badc0de
M 2 3e 3
T config_words
W 7 0
W 6 11111111
W 6 22222222
W 6 33333333
K 0 33333333
K 1 22222222
W 7 1
W 6 44444444
K 1 44444444
K 0 33333333
T interrupt
I 0
D
N 2
I 0
R 1e 00000100
W 1e 00010000
N 1
I 1
R 1e 00010100
W 1e 00010100
N 1
I 0
R 1e 00010000
T start
S 1
S 0

// File: testbench/aipTb.sv
`timescale 1ns/1ps

module aipTb
  import hostMapPkg::*;
();

  localparam int    BankCount = 3;
  localparam int    BankDepth [BankCount] = '{32, 32, 64};
  localparam string CasesFile = "testbench/aipCases.txt";

  logic           clk;
  logic           rst;
  cmdCodeT        cmdCode;
  dataWordT       hostDataIn;
  logic           hostWrite;
  logic           hostStart;
  dataWordT       hostDataOut;
  logic           hostInt;
  logic [15:0]    coreRdAddr [BankCount];
  dataWordT       coreRdData [BankCount];
  dataWordT [1:0] confData;
  logic           coreStart;
  logic           coreBusy;
  logic           coreDone;

  // Expected bank contents and write pointers
  dataWordT modelMem [BankCount][64];
  int       modelPtr [BankCount];

  integer seed = 32'hcd56_614f;
  int     errors = 0;
  int     checks = 0;
  int     testErrors = 0;
  int     testsRun = 0;
  int     testsFailed = 0;
  int     cycleCount = 0;
  int     cycleLimit = 0;
  string  testName;
  logic   testOpen = 1'b0;

  aipTop DUT (
    .clk          (clk),
    .rst          (rst),
    .cmdCode_i    (cmdCode),
    .hostData_i   (hostDataIn),
    .hostWrite_i  (hostWrite),
    .hostStart_i  (hostStart),
    .hostData_o   (hostDataOut),
    .hostInt_o    (hostInt),
    .coreRdAddr_i (coreRdAddr),
    .coreRdData_o (coreRdData),
    .confData_o   (confData),
    .coreStart_o  (coreStart),
    .coreBusy_i   (coreBusy),
    .coreDone_i   (coreDone)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run went past %0d cycles", cycleLimit);
      $display("Something failed");
      $finish;
    end
  end

  task automatic checkWord(input string sigName, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %0s: got 0x%08h expected 0x%08h", sigName, got, exp);
      errors++;
      testErrors++;
    end
  endtask

  task automatic finishTest();
    if (testOpen) begin
      testsRun++;
      if (testErrors == 0) begin
        $display("Test %0s: passed", testName);
      end else begin
        testsFailed++;
        $display("Test %0s: failed with %0d errors", testName, testErrors);
      end
    end
    testErrors = 0;
  endtask

  // One host write, bank codes also update the model
  task automatic hostWriteOp(input cmdCodeT code, input dataWordT data);
    int b;
    b = int'(code) / 2;
    cmdCode    = code;
    hostDataIn = data;
    hostWrite  = 1'b1;
    if (int'(code) < 2 * BankCount) begin
      if (code[0]) begin
        modelPtr[b] = int'(data[5:0]) % BankDepth[b];
      end else begin
        modelMem[b][modelPtr[b]] = data;
        modelPtr[b] = (modelPtr[b] + 1) % BankDepth[b];
      end
    end
    @(negedge clk);
    hostWrite = 1'b0;
  endtask

  task automatic fillOp(input int bank, input int count);
    dataWordT word;
    for (int i = 0; i < count; i++) begin
      word = $random(seed);
      hostWriteOp(cmdCodeT'(2 * bank), word);
    end
  endtask

  // Back to back reads, each word checked one cycle after its address
  task automatic burstReadOp(input int bank, input int addr, input int count);
    int       a;
    dataWordT exp;
    for (int i = 0; i <= count; i++) begin
      if (i > 0) begin
        checkWord($sformatf("coreRdData_o[%0d]", bank), coreRdData[bank], exp);
      end
      if (i < count) begin
        a = (addr + i) % BankDepth[bank];
        exp = modelMem[bank][a];
        coreRdAddr[bank] = 16'(a);
        @(negedge clk);
      end
    end
  endtask

  initial begin
    integer           fd;
    integer           status;
    int               lineCount;
    logic [8*32-1:0]  opTok;
    logic [8*32-1:0]  nameTok;
    logic [8*128-1:0] lineBuf;
    logic [31:0]      argA;
    logic [31:0]      argB;
    logic [31:0]      argC;
    lineCount  = 0;
    rst        = 1'b0;
    cmdCode    = '0;
    hostDataIn = '0;
    hostWrite  = 1'b0;
    hostStart  = 1'b0;
    coreBusy   = 1'b0;
    coreDone   = 1'b0;
    for (int b = 0; b < BankCount; b++) begin
      coreRdAddr[b] = '0;
      modelPtr[b]   = 0;
    end
    fd = $fopen(CasesFile, "r");
    if (fd == 0) begin
      $display("Could not open the cases file %0s", CasesFile);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        status = $fgets(lineBuf, fd);
        if (status > 0) lineCount++;
      end
      $fclose(fd);
      cycleLimit = 16 + 8 * lineCount;
      repeat (16) @(negedge clk);
      rst = 1'b1;
      fd = $fopen(CasesFile, "r");
      while ($fscanf(fd, "%s", opTok) == 1) begin
        case (opTok)
          "#": status = $fgets(lineBuf, fd);
          "T": begin
            finishTest();
            status = $fscanf(fd, "%s", nameTok);
            testName = string'(nameTok);
            testOpen = 1'b1;
          end
          "W": begin
            status = $fscanf(fd, "%h %h", argA, argB);
            hostWriteOp(cmdCodeT'(argA), argB);
          end
          "F": begin
            status = $fscanf(fd, "%h %h", argA, argB);
            fillOp(argA, argB);
          end
          "M": begin
            status = $fscanf(fd, "%h %h %h", argA, argB, argC);
            burstReadOp(argA, argB, argC);
          end
          "C": begin
            status = $fscanf(fd, "%h %h %h", argA, argB, argC);
            coreRdAddr[argA] = argB[15:0];
            @(negedge clk);
            checkWord($sformatf("coreRdData_o[%0d]", argA), coreRdData[argA], argC);
          end
          "R": begin
            status = $fscanf(fd, "%h %h", argA, argB);
            cmdCode = cmdCodeT'(argA);
            #1;
            checkWord("hostData_o", hostDataOut, argB); // Combinational readback
            @(negedge clk);
          end
          "K": begin
            status = $fscanf(fd, "%h %h", argA, argB);
            checkWord($sformatf("confData_o[%0d]", argA), confData[argA], argB);
            @(negedge clk);
          end
          "B": begin
            status = $fscanf(fd, "%h", argA);
            coreBusy = argA[0];
            @(negedge clk);
          end
          "D": begin
            coreDone = 1'b1;
            @(negedge clk);
            coreDone = 1'b0;
          end
          "S": begin
            status = $fscanf(fd, "%h", argA);
            hostStart = argA[0];
            #1;
            checkWord("coreStart_o", {31'b0, coreStart}, {31'b0, argA[0]});
            @(negedge clk);
          end
          "I": begin
            status = $fscanf(fd, "%h", argA);
            checkWord("hostInt_o", {31'b0, hostInt}, argA);
            @(negedge clk);
          end
          "N": begin
            status = $fscanf(fd, "%h", argA);
            repeat (argA) @(negedge clk);
          end
          default: begin
            $display("Unknown operation %0s in the cases file", opTok);
            errors++;
            status = $fgets(lineBuf, fd);
          end
        endcase
      end
      finishTest();
      $fclose(fd);
      if (testsRun == 0) begin
        $display("No tests were found in the cases file");
        errors++;
      end
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: testbench/aipTop_checker.sv
`timescale 1ns/1ps

module aipTop_checker
  import hostMapPkg::*, coreCfgPkg::*;
(
  input logic                  clk,
  input logic                  rst,
  input cmdCodeT               cmdCode_i,
  input dataWordT              hostData_i,
  input logic                  hostInt_i,
  input logic                  intEn_i,
  input logic [2*NumBanks-1:0] bankHits_i // Data and pointer strobes of all banks
);

  onlyOneBank: assert property (@(posedge clk) disable iff (!rst) $onehot0(bankHits_i))
    else $error("Several bank strobes active in one cycle");

  // Interrupt is registered, so it follows the enable of the cycle before
  intNeedsEnable: assert property (@(posedge clk) disable iff (!rst)
    hostInt_i |-> $past(intEn_i))
    else $error("Interrupt high while the enable was clear");

  idReadback: assert property (@(posedge clk) disable iff (!rst)
    (cmdCode_i == CmdId) |-> (hostData_i == CoreId))
    else $error("ID readback does not return the core ID");

endmodule

bind aipTop aipTop_checker uChecker (
  .clk        (clk),
  .rst        (rst),
  .cmdCode_i  (cmdCode_i),
  .hostData_i (hostData_o),
  .hostInt_i  (hostInt_o),
  .intEn_i    (uStatus.intEn),
  .bankHits_i ({bankWr[2].ptrLoad, bankWr[2].wrEn,
                bankWr[1].ptrLoad, bankWr[1].wrEn,
                bankWr[0].ptrLoad, bankWr[0].wrEn})
);
